/* mod_defs.svh */
`ifndef MOD_DEFS_SVH
`define MOD_DEFS_SVH

// words per modulation segment
// any power of two works
`define MOD_WORDS 256

// double-buffered modulation store
`define MOD_SEGMENTS 2

// one intensity sample, two per memory word
`define SAMPLE_W 8

// word address inside one segment
`define MOD_WORD_AW ($clog2(`MOD_WORDS))

// segment bit(s) on top of the word address
`define MOD_MEM_AW ($clog2(`MOD_SEGMENTS) + `MOD_WORD_AW)

// sample index, two samples per word
`define MOD_IDX_W (`MOD_WORD_AW + 1)

// memory word holds the even sample low, odd sample high
`define MOD_DATA_W (2 * `SAMPLE_W)

`endif

/* mod_pkg.sv */
`default_nettype none
`include "mod_defs.svh"

package mod_pkg;

  // bank select from cpu_addr[16:15]
  // values 2 and 3 are not decoded
  typedef enum logic [1:0] {
    BANK_CONTROLLER = 2'd0,
    BANK_MOD        = 2'd1
  } bank_sel_t;

  // controller register map, one word per register
  typedef enum logic [13:0] {
    ADDR_CTL_FLAG           = 14'h0000,
    ADDR_MOD_MEM_WR_SEGMENT = 14'h0001,
    ADDR_MOD_RD_SEGMENT     = 14'h0002,
    ADDR_MOD_CYCLE          = 14'h0003,
    ADDR_MOD_FREQ_DIV       = 14'h0004
  } ctl_addr_t;

  // one completed host write
  typedef struct packed {
    bank_sel_t   select;
    logic [13:0] addr;
    logic [15:0] data;
  } bus_write_t;

  // playback settings towards the sampler
  typedef struct packed {
    logic                  enable;
    logic                  rd_segment;
    logic [`MOD_IDX_W-1:0] cycle;
    logic [15:0]           freq_div;
  } mod_cfg_t;

endpackage

`default_nettype wire

/* cpu_bus_capture.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mod_defs.svh"

module cpu_bus_capture (
  input  wire logic        CPU_CKIO,
  input  wire logic        rst_n,
  input  wire logic [16:0] cpu_addr,
  input  wire logic [15:0] cpu_data,
  input  wire logic        cpu_cs1_n,
  input  wire logic        cpu_we0_n,
  output logic             wr_req,
  input  wire logic        wr_ack,
  output mod_pkg::bus_write_t wr_rec
);

  import mod_pkg::*;

  // strobe level seen on the previous edge
  logic we_n_q;
  // end of a write cycle on the bus
  logic wr_done;
  // no exchange in flight, both phases back at zero
  logic slot_free;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      we_n_q <= 1'b1;
    end else begin
      we_n_q <= cpu_we0_n;
    end
  end

  // we0_n going back high closes the write
  // chip select must still be asserted
  assign wr_done   = !cpu_cs1_n && cpu_we0_n && !we_n_q;
  assign slot_free = !wr_req && !wr_ack;

  // producer side of the four-phase exchange
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      wr_req <= 1'b0;
    end else if (wr_done && slot_free) begin
      wr_req <= 1'b1;
    end else if (wr_req && wr_ack) begin
      // ack seen, release request
      wr_req <= 1'b0;
    end
  end

  // holding slot, frozen until the next accepted write
  // writes that land on a busy slot are lost
  always_ff @(posedge CPU_CKIO) begin
    if (wr_done && slot_free) begin
      wr_rec.select <= bank_sel_t'(cpu_addr[16:15]);
      // bit 0 is not part of the word address
      wr_rec.addr   <= cpu_addr[14:1];
      wr_rec.data   <= cpu_data;
    end
  end

endmodule

`default_nettype wire

/* ctl_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mod_defs.svh"

module ctl_regs (
  input  wire logic                      CPU_CKIO,
  input  wire logic                      rst_n,
  input  wire logic                      wr_req,
  output logic                           wr_ack,
  input  wire mod_pkg::bus_write_t       wr_rec,
  output logic                           mem_we,
  output logic [`MOD_MEM_AW-1:0]         mem_wr_addr,
  output logic [`MOD_DATA_W-1:0]         mem_wr_data,
  output mod_pkg::mod_cfg_t              cfg
);

  import mod_pkg::*;

  // new request not yet acknowledged
  logic                  apply;
  // segment that takes modulation writes
  logic                  wr_segment;
  logic                  enable_r;
  logic                  rd_segment_r;
  logic [`MOD_IDX_W-1:0] cycle_r;
  logic [15:0]           freq_div_r;

  assign apply = wr_req && !wr_ack;

  // consumer side of the handshake
  // ack follows the apply cycle, drops once req is gone
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      wr_ack <= 1'b0;
    end else if (apply) begin
      wr_ack <= 1'b1;
    end else if (!wr_req) begin
      wr_ack <= 1'b0;
    end
  end

  // register decode, unknown addresses are dropped
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      enable_r     <= 1'b0;
      wr_segment   <= 1'b0;
      rd_segment_r <= 1'b0;
      cycle_r      <= '0;
      freq_div_r   <= '0;
    end else if (apply && (wr_rec.select == BANK_CONTROLLER)) begin
      case (wr_rec.addr)
        ADDR_CTL_FLAG:           enable_r     <= wr_rec.data[0];
        ADDR_MOD_MEM_WR_SEGMENT: wr_segment   <= wr_rec.data[0];
        ADDR_MOD_RD_SEGMENT:     rd_segment_r <= wr_rec.data[0];
        ADDR_MOD_CYCLE:          cycle_r      <= wr_rec.data[`MOD_IDX_W-1:0];
        ADDR_MOD_FREQ_DIV:       freq_div_r   <= wr_rec.data;
        default: ;
      endcase
    end
  end

  // memory write in the apply cycle
  // addresses past one segment are discarded
  assign mem_we      = apply && (wr_rec.select == BANK_MOD) && (wr_rec.addr < `MOD_WORDS);
  assign mem_wr_addr = {wr_segment, wr_rec.addr[`MOD_WORD_AW-1:0]};
  assign mem_wr_data = wr_rec.data;

  // settings registered once more towards the sampler
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cfg <= '0;
    end else begin
      cfg.enable     <= enable_r;
      cfg.rd_segment <= rd_segment_r;
      cfg.cycle      <= cycle_r;
      cfg.freq_div   <= freq_div_r;
    end
  end

endmodule

`default_nettype wire

/* mod_memory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mod_defs.svh"

module mod_memory (
  input  wire logic                   CPU_CKIO,
  input  wire logic                   we,
  input  wire logic [`MOD_MEM_AW-1:0] wr_addr,
  input  wire logic [`MOD_DATA_W-1:0] wr_data,
  input  wire logic [`MOD_MEM_AW-1:0] rd_addr,
  output logic      [`MOD_DATA_W-1:0] rd_data
);

  // all segments stacked, segment bit on top of the address
  localparam int DEPTH = `MOD_SEGMENTS * `MOD_WORDS;

  // sample store, contents undefined until loaded
  logic [`MOD_DATA_W-1:0] mem [DEPTH];

  // host write port
  always_ff @(posedge CPU_CKIO) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // playback read port, one cycle latency
  // same-address collision returns the old word
  always_ff @(posedge CPU_CKIO) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* mod_sampler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mod_defs.svh"

module mod_sampler (
  input  wire logic                   CPU_CKIO,
  input  wire logic                   rst_n,
  input  wire mod_pkg::mod_cfg_t      cfg,
  output logic [`MOD_MEM_AW-1:0]      rd_addr,
  input  wire logic [`MOD_DATA_W-1:0] rd_data,
  output logic [`SAMPLE_W-1:0]        mod_value,
  output logic                        mod_valid
);

  // effective divider, never below 2
  logic [15:0]           div_len;
  logic [15:0]           div_cnt;
  // sample index inside the segment
  logic [`MOD_IDX_W-1:0] idx;
  // last cycle of a sample period
  logic                  tick;
  // memory word for the tick is on rd_data
  logic                  fetch_q;
  // odd sample sits in the high byte
  logic                  byte_sel_q;

  assign div_len = (cfg.freq_div < 16'd2) ? 16'd2 : cfg.freq_div;
  assign tick    = (div_cnt >= div_len - 16'd1);

  // word holding the current sample, live segment select
  assign rd_addr = {cfg.rd_segment, idx[`MOD_IDX_W-1:1]};

  // divider, index and pulse pipeline
  // held at zero while playback is off
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n || !cfg.enable) begin
      div_cnt   <= '0;
      idx       <= '0;
      fetch_q   <= 1'b0;
      mod_valid <= 1'b0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 16'd1;
      if (tick) begin
        // wrap after the last index of the cycle
        idx <= (idx >= cfg.cycle) ? '0 : idx + 1'b1;
      end
      fetch_q   <= tick;
      mod_valid <= fetch_q;
    end
  end

  // byte lane for the word being read
  always_ff @(posedge CPU_CKIO) begin
    if (tick) begin
      byte_sel_q <= idx[0];
    end
  end

  // output sample, kept after playback stops
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      mod_value <= '0;
    end else if (fetch_q) begin
      mod_value <= byte_sel_q ? rd_data[`MOD_DATA_W-1:`SAMPLE_W] : rd_data[`SAMPLE_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* mod_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mod_defs.svh"

module mod_subsystem (
  input  wire logic                CPU_CKIO,
  input  wire logic                rst_n,
  input  wire logic [16:0]         cpu_addr,
  input  wire logic [15:0]         cpu_data,
  input  wire logic                cpu_cs1_n,
  input  wire logic                cpu_we0_n,
  output logic [`SAMPLE_W-1:0]     mod_value,
  output logic                     mod_valid
);

  import mod_pkg::*;

  // capture to register block handshake
  logic                   wr_req;
  logic                   wr_ack;
  bus_write_t             wr_rec;
  // register block to memory write port
  logic                   mem_we;
  logic [`MOD_MEM_AW-1:0] mem_wr_addr;
  logic [`MOD_DATA_W-1:0] mem_wr_data;
  // playback settings and read port
  mod_cfg_t               cfg;
  logic [`MOD_MEM_AW-1:0] rd_addr;
  logic [`MOD_DATA_W-1:0] rd_data;

  // host bus side
  cpu_bus_capture i_cpu_bus_capture (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .cpu_addr (cpu_addr),
    .cpu_data (cpu_data),
    .cpu_cs1_n(cpu_cs1_n),
    .cpu_we0_n(cpu_we0_n),
    .wr_req   (wr_req),
    .wr_ack   (wr_ack),
    .wr_rec   (wr_rec)
  );

  ctl_regs i_ctl_regs (
    .CPU_CKIO   (CPU_CKIO),
    .rst_n      (rst_n),
    .wr_req     (wr_req),
    .wr_ack     (wr_ack),
    .wr_rec     (wr_rec),
    .mem_we     (mem_we),
    .mem_wr_addr(mem_wr_addr),
    .mem_wr_data(mem_wr_data),
    .cfg        (cfg)
  );

  mod_memory i_mod_memory (
    .CPU_CKIO(CPU_CKIO),
    .we      (mem_we),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // playback side
  mod_sampler i_mod_sampler (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .mod_value(mod_value),
    .mod_valid(mod_valid)
  );

endmodule

`default_nettype wire

/* mod_subsystem_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_subsystem_assertions (
  input wire logic                CPU_CKIO,
  input wire logic                rst_n,
  input wire logic                cpu_cs1_n,
  input wire logic                cpu_we0_n,
  input wire logic                wr_req,
  input wire logic                wr_ack,
  input wire mod_pkg::bus_write_t wr_rec
);

  // failed assertions so far
  int error_count = 0;

  // record frozen for the whole request phase
  a_rec_stable: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    (wr_req && $past(wr_req)) |-> $stable(wr_rec))
  else begin
    $error("wr_rec changed while wr_req was held");
    error_count++;
  end

  // ack only answers an open request
  a_ack_after_req: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    $rose(wr_ack) |-> $past(wr_req))
  else begin
    $error("wr_ack rose without wr_req");
    error_count++;
  end

  // strobe back high with chip select low ends a write
  // the single slot must be free by then
  a_no_overrun: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    (!cpu_cs1_n && cpu_we0_n && !$past(cpu_we0_n)) |-> !(wr_req || wr_ack))
  else begin
    $error("bus write completed during an open handshake and was dropped");
    error_count++;
  end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic CPU_CKIO
);

  // free-running, starts low
  initial begin
    CPU_CKIO = 1'b0;
    forever #(PERIOD / 2) CPU_CKIO = ~CPU_CKIO;
  end

endmodule

`default_nettype wire

/* tb_mod_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mod_defs.svh"

module tb_mod_subsystem;

  import mod_pkg::*;

  localparam int CLK_PERIOD   = 40;
  // inputs change this long after the rising edge
  localparam int DRIVE_DELAY  = 4;
  localparam int RESET_CYCLES = 5;
  // words loaded per segment with two samples each
  localparam int LOAD_WORDS   = 16;
  // per-test budgets from about five cycles per bus write plus the pulse trains
  localparam int T1_CYCLES    = 40;
  localparam int T2_CYCLES    = 350;
  localparam int T3_CYCLES    = 400;
  localparam int T4_CYCLES    = 120;
  localparam int T5_CYCLES    = 120;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                   + T4_CYCLES + T5_CYCLES + 200;

  logic                 CPU_CKIO;
  logic                 rst_n;
  logic [16:0]          cpu_addr;
  logic [15:0]          cpu_data;
  logic                 cpu_cs1_n;
  logic                 cpu_we0_n;
  logic [`SAMPLE_W-1:0] mod_value;
  logic                 mod_valid;
  // sample data source
  logic [31:0]          lfsr_state;
  // expected samples by segment and sample index
  logic [`SAMPLE_W-1:0] model [`MOD_SEGMENTS][2*LOAD_WORDS];

  tb_clock #(.PERIOD(CLK_PERIOD)) i_tb_clock (.CPU_CKIO(CPU_CKIO));

  mod_subsystem i_mod_subsystem (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .cpu_addr (cpu_addr),
    .cpu_data (cpu_data),
    .cpu_cs1_n(cpu_cs1_n),
    .cpu_we0_n(cpu_we0_n),
    .mod_value(mod_value),
    .mod_valid(mod_valid)
  );

  // handshake checks on the capture/register link
  bind mod_subsystem mod_subsystem_assertions i_mod_subsystem_assertions (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .cpu_cs1_n(cpu_cs1_n),
    .cpu_we0_n(cpu_we0_n),
    .wr_req   (wr_req),
    .wr_ack   (wr_ack),
    .wr_rec   (wr_rec)
  );

  // x^32 + x^22 + x^2 + x + 1 shifting left
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit
  task automatic random_byte(output logic [7:0] v);
    v = '0;
    repeat (8) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, exp));
    end
  endtask

  // setup, strobe low two cycles, strobe high, then chip select off
  task automatic bus_write(input bank_sel_t bank, input logic [13:0] addr,
                           input logic [15:0] data);
    @(posedge CPU_CKIO);
    #DRIVE_DELAY;
    cpu_cs1_n = 1'b0;
    cpu_addr  = {bank, addr, 1'b0};
    cpu_data  = data;
    @(posedge CPU_CKIO);
    #DRIVE_DELAY;
    cpu_we0_n = 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    #DRIVE_DELAY;
    cpu_we0_n = 1'b1;
    // write completes on this edge
    @(posedge CPU_CKIO);
    #DRIVE_DELAY;
    cpu_cs1_n = 1'b1;
  endtask

  task automatic write_reg(input logic [13:0] addr, input logic [15:0] data);
    bus_write(BANK_CONTROLLER, addr, data);
  endtask

  // fresh random words into one segment and the model
  task automatic load_segment(input int seg);
    logic [7:0] lo;
    logic [7:0] hi;
    write_reg(ADDR_MOD_MEM_WR_SEGMENT, 16'(seg));
    for (int w = 0; w < LOAD_WORDS; w++) begin
      random_byte(lo);
      random_byte(hi);
      // even sample in the low byte
      model[seg][2*w]   = lo;
      model[seg][2*w+1] = hi;
      bus_write(BANK_MOD, 14'(w), {hi, lo});
    end
  endtask

  // gap counts edges up to and including the pulse
  task automatic wait_pulse(input int limit, output int gap);
    gap = 0;
    do begin
      @(posedge CPU_CKIO);
      #1;
      gap++;
      if (gap > limit) fail_run("mod_valid pulse did not arrive in time");
    end while (!mod_valid);
  endtask

  task automatic expect_quiet(input int cycles, input bit zero_value);
    repeat (cycles) begin
      @(posedge CPU_CKIO);
      #1;
      check_value("mod_valid", mod_valid, 0);
      if (zero_value) check_value("mod_value", mod_value, 0);
    end
  endtask

  // pulse train of one segment with index wrap after last
  task automatic play_check(input int seg, input int last, input int div, input int count);
    int gap;
    int div_eff;
    // divider below 2 behaves as 2
    div_eff = (div < 2) ? 2 : div;
    for (int k = 0; k < count; k++) begin
      wait_pulse((k == 0) ? div_eff + 12 : div_eff + 4, gap);
      if (k > 0) check_value("mod_valid spacing", gap, div_eff);
      check_value("mod_value", mod_value, model[seg][k % (last + 1)]);
    end
  endtask

  task automatic test_reset_state();
    expect_quiet(20, 1'b1);
  endtask

  task automatic test_play_segment0();
    load_segment(0);
    write_reg(ADDR_MOD_CYCLE, 16'd15);
    write_reg(ADDR_MOD_FREQ_DIV, 16'd5);
    write_reg(ADDR_MOD_RD_SEGMENT, 16'd0);
    write_reg(ADDR_CTL_FLAG, 16'd1);
    play_check(0, 15, 5, 32);
  endtask

  task automatic test_segment_independence();
    write_reg(ADDR_CTL_FLAG, 16'd0);
    load_segment(1);
    write_reg(ADDR_MOD_RD_SEGMENT, 16'd1);
    write_reg(ADDR_CTL_FLAG, 16'd1);
    play_check(1, 15, 5, 16);
    // segment 0 must be untouched by the segment 1 load
    write_reg(ADDR_CTL_FLAG, 16'd0);
    write_reg(ADDR_MOD_RD_SEGMENT, 16'd0);
    write_reg(ADDR_CTL_FLAG, 16'd1);
    play_check(0, 15, 5, 16);
  endtask

  task automatic test_odd_cycle();
    write_reg(ADDR_CTL_FLAG, 16'd0);
    write_reg(ADDR_MOD_CYCLE, 16'd6);
    write_reg(ADDR_MOD_FREQ_DIV, 16'd3);
    write_reg(ADDR_CTL_FLAG, 16'd1);
    play_check(0, 6, 3, 14);
  endtask

  task automatic test_disable_min_div();
    write_reg(ADDR_CTL_FLAG, 16'd0);
    // disable reaches the sampler through two register stages
    repeat (6) @(posedge CPU_CKIO);
    expect_quiet(20, 1'b0);
    write_reg(ADDR_MOD_FREQ_DIV, 16'd0);
    write_reg(ADDR_CTL_FLAG, 16'd1);
    play_check(0, 6, 0, 14);
  endtask

  initial begin
    lfsr_state = 32'hcc78;
    rst_n      = 1'b0;
    cpu_addr   = '0;
    cpu_data   = '0;
    cpu_cs1_n  = 1'b1;
    cpu_we0_n  = 1'b1;
    repeat (RESET_CYCLES) @(posedge CPU_CKIO);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    test_reset_state();
    test_play_segment0();
    test_segment_independence();
    test_odd_cycle();
    test_disable_min_div();
    if (i_mod_subsystem.i_mod_subsystem_assertions.error_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run("bound handshake assertions reported failures");
    end
  end

  // first bound assertion failure ends the run
  initial begin
    wait (i_mod_subsystem.i_mod_subsystem_assertions.error_count != 0);
    fail_run("a bound handshake assertion failed");
  end

  // hard stop on a hung test
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
mod_pkg.sv
cpu_bus_capture.sv
ctl_regs.sv
mod_memory.sv
mod_sampler.sv
mod_subsystem.sv
mod_subsystem_assertions.sv
tb_clock.sv
tb_mod_subsystem.sv

/* Bender.yml */
package:
  name: mod_subsystem

sources:
  - include_dirs:
      - .
    files:
      - mod_pkg.sv
      - cpu_bus_capture.sv
      - ctl_regs.sv
      - mod_memory.sv
      - mod_sampler.sv
      - mod_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - mod_subsystem_assertions.sv
      - tb_clock.sv
      - tb_mod_subsystem.sv
